// ==== hdl/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    // ST7789 command codes used by the controller
    typedef enum logic [7:0] {
        CMD_SWRESET = 8'h01,
        CMD_SLPOUT  = 8'h11,
        CMD_INVON   = 8'h21,
        CMD_DISPON  = 8'h29,
        CMD_CASET   = 8'h2A,
        CMD_RASET   = 8'h2B,
        CMD_RAMWR   = 8'h2C
    } lcd_cmd_e;

    typedef struct packed {
        logic [7:0] data;
        logic       user; // parameter or pixel byte
        logic       last; // last byte of packet
    } lcd_byte_t;

    typedef struct packed {
        logic [7:0] x_start;
        logic [7:0] x_end;
        logic [7:0] y_start;
        logic [7:0] y_end;
    } seg_rect_t;

    typedef struct packed {
        logic [15:0] x_low;
        logic [15:0] x_high;
        logic [15:0] y_low;
        logic [15:0] y_high;
    } lcd_window_t;

    typedef logic [6:0] digit_seg_t; // bit 0 = a ... bit 6 = g

    typedef struct packed {
        digit_seg_t hour_h;
        digit_seg_t hour_l;
        digit_seg_t min_h;
        digit_seg_t min_l;
        digit_seg_t sec_h;
        digit_seg_t sec_l;
    } time_digits_t;

    localparam int NUM_DIGITS       = 6;
    localparam int NUM_SEGMENTS     = 7;
    localparam int PANEL_LAST_COORD = 239;

endpackage

`default_nettype wire

// ==== hdl/segment_rom.sv ====
`default_nettype none

module segment_rom (
    input  wire  logic              CLK,
    input  wire  logic [2:0]        seg_index,
    output lcd_pkg::seg_rect_t      seg_rect
);

    import lcd_pkg::*;

    // 20x40 cell with 4 pixel strokes
    always_ff @(posedge CLK) begin
        case (seg_index)
            3'd0: seg_rect <= '{x_start: 8'd0,  x_end: 8'd19, y_start: 8'd0,  y_end: 8'd3};
            3'd1: seg_rect <= '{x_start: 8'd16, x_end: 8'd19, y_start: 8'd0,  y_end: 8'd19};
            3'd2: seg_rect <= '{x_start: 8'd16, x_end: 8'd19, y_start: 8'd20, y_end: 8'd39};
            3'd3: seg_rect <= '{x_start: 8'd0,  x_end: 8'd19, y_start: 8'd36, y_end: 8'd39};
            3'd4: seg_rect <= '{x_start: 8'd0,  x_end: 8'd3,  y_start: 8'd20, y_end: 8'd39};
            3'd5: seg_rect <= '{x_start: 8'd0,  x_end: 8'd3,  y_start: 8'd0,  y_end: 8'd19};
            3'd6: seg_rect <= '{x_start: 8'd0,  x_end: 8'd19, y_start: 8'd18, y_end: 8'd21};
            default: seg_rect <= '0;
        endcase
    end

    // controller never walks past segment g
    a_seg_index_range : assert property (
        @(posedge CLK) !$isunknown(seg_index) |-> seg_index < 3'(NUM_SEGMENTS)
    );

endmodule

`default_nettype wire

// ==== hdl/window_calc.sv ====
`default_nettype none

module window_calc #(
    parameter int SYMBOL_PITCH = 30,
    parameter int OFFSET_X     = 0,
    parameter int OFFSET_Y     = 0
) (
    input  wire  logic                CLK,
    input  wire  logic [2:0]          digit_index,
    input  wire  lcd_pkg::seg_rect_t  seg_rect,
    output lcd_pkg::lcd_window_t      window,
    output logic [15:0]               pixel_count
);

    logic [15:0] x_base;
    logic [15:0] rect_width;
    logic [15:0] rect_height;

    // left edge of the digit cell on the panel
    assign x_base = 16'(OFFSET_X) + 16'(digit_index) * 16'(SYMBOL_PITCH);

    assign rect_width  = 16'(seg_rect.x_end) - 16'(seg_rect.x_start) + 16'd1;
    assign rect_height = 16'(seg_rect.y_end) - 16'(seg_rect.y_start) + 16'd1;

    always_ff @(posedge CLK) begin
        window.x_low  <= x_base + 16'(seg_rect.x_start);
        window.x_high <= x_base + 16'(seg_rect.x_end);
        window.y_low  <= 16'(OFFSET_Y) + 16'(seg_rect.y_start);
        window.y_high <= 16'(OFFSET_Y) + 16'(seg_rect.y_end);
        pixel_count   <= rect_width * rect_height; // pixels in rectangle
    end

endmodule

`default_nettype wire

// ==== hdl/stream_out.sv ====
`default_nettype none

module stream_out (
    input  wire  logic               CLK,
    input  wire  logic               RESET,
    input  wire  lcd_pkg::lcd_byte_t byte_in,
    input  wire  logic               byte_push,
    output logic                     byte_space,
    output logic [7:0]               m_axis_tdata,
    output logic                     m_axis_tuser,
    output logic                     m_axis_tlast,
    output logic                     m_axis_tvalid,
    input  wire  logic               m_axis_tready
);

    import lcd_pkg::*;

    lcd_byte_t out_reg;
    logic      out_valid;

    // free now or emptied at this edge
    assign byte_space = !out_valid || m_axis_tready;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            out_valid <= 1'b0;
        end else if (byte_push) begin
            out_valid <= 1'b1;
        end else if (m_axis_tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (byte_push) begin
            out_reg <= byte_in;
        end
    end

    assign m_axis_tdata  = out_reg.data;
    assign m_axis_tuser  = out_reg.user;
    assign m_axis_tlast  = out_reg.last;
    assign m_axis_tvalid = out_valid;

    a_push_has_space : assert property (
        @(posedge CLK) disable iff (RESET) byte_push |-> byte_space
    );

    a_stall_stable : assert property (
        @(posedge CLK) disable iff (RESET)
        out_valid && !m_axis_tready |=> out_valid && $stable(out_reg)
    );

endmodule

`default_nettype wire

// ==== hdl/lcd_ctrl.sv ====
`default_nettype none

module lcd_ctrl #(
    parameter int          PAUSE_CYCLES     = 500,
    parameter logic [23:0] FONT_COLOR       = 24'hFFFFFF,
    parameter logic [23:0] BACKGROUND_COLOR = 24'h000000
) (
    input  wire  logic                  CLK,
    input  wire  logic                  RESET,
    input  wire  lcd_pkg::time_digits_t time_digits,
    input  wire  logic                  time_valid,
    input  wire  logic                  byte_space,
    output lcd_pkg::lcd_byte_t          byte_in,
    output logic                        byte_push,
    output logic [2:0]                  seg_index,
    output logic [2:0]                  digit_index,
    input  wire  lcd_pkg::lcd_window_t  window,
    input  wire  logic [15:0]           pixel_count
);

    import lcd_pkg::*;

    localparam int PAUSE_W = $clog2(PAUSE_CYCLES + 1);

    typedef enum logic [3:0] {
        ST_START,
        ST_SWRESET,
        ST_PAUSE,
        ST_SLPOUT,
        ST_INVON,
        ST_DISPON,
        ST_CASET_FULL,
        ST_RASET_FULL,
        ST_IDLE,
        ST_SETTLE,
        ST_CASET,
        ST_RASET,
        ST_RAMWR,
        ST_PIXELS
    } state_e;

    state_e       state;
    logic [2:0]   byte_cnt;
    logic [15:0]  pix_cnt;
    logic [PAUSE_W-1:0] pause_cnt;
    logic         settle_cnt;
    time_digits_t digits_q;
    digit_seg_t   cur_digit;
    logic         seg_on;
    logic         win_done;
    logic         pix_done;
    logic         frame_done;
    lcd_cmd_e     win_cmd;
    logic [15:0]  win_lo;
    logic [15:0]  win_hi;
    logic [23:0]  color;

    always_comb begin
        case (digit_index)
            3'd0: cur_digit = digits_q.hour_h;
            3'd1: cur_digit = digits_q.hour_l;
            3'd2: cur_digit = digits_q.min_h;
            3'd3: cur_digit = digits_q.min_l;
            3'd4: cur_digit = digits_q.sec_h;
            default: cur_digit = digits_q.sec_l;
        endcase
    end

    assign seg_on = cur_digit[seg_index];
    assign color  = seg_on ? FONT_COLOR : BACKGROUND_COLOR;

    assign win_done   = byte_push && byte_cnt == 3'd4;
    assign pix_done   = byte_push && byte_cnt == 3'd2 && pix_cnt == pixel_count - 16'd1;
    assign frame_done = seg_index == 3'(NUM_SEGMENTS - 1) && digit_index == 3'(NUM_DIGITS - 1);

    // window packet source
    always_comb begin
        case (state)
            ST_CASET_FULL: begin
                win_cmd = CMD_CASET;
                win_lo  = 16'd0;
                win_hi  = 16'(PANEL_LAST_COORD);
            end
            ST_RASET_FULL: begin
                win_cmd = CMD_RASET;
                win_lo  = 16'd0;
                win_hi  = 16'(PANEL_LAST_COORD);
            end
            ST_CASET: begin
                win_cmd = CMD_CASET;
                win_lo  = window.x_low;
                win_hi  = window.x_high;
            end
            default: begin
                win_cmd = CMD_RASET;
                win_lo  = window.y_low;
                win_hi  = window.y_high;
            end
        endcase
    end

    always_comb begin
        byte_in   = '{data: 8'h00, user: 1'b0, last: 1'b1};
        byte_push = 1'b0;
        case (state)
            ST_SWRESET, ST_SLPOUT, ST_INVON, ST_DISPON: begin
                byte_push = byte_space;
                case (state)
                    ST_SWRESET: byte_in.data = CMD_SWRESET;
                    ST_SLPOUT:  byte_in.data = CMD_SLPOUT;
                    ST_INVON:   byte_in.data = CMD_INVON;
                    default:    byte_in.data = CMD_DISPON;
                endcase
            end
            ST_CASET_FULL, ST_RASET_FULL, ST_CASET, ST_RASET: begin
                byte_push    = byte_space;
                byte_in.user = byte_cnt != 3'd0;
                byte_in.last = byte_cnt == 3'd4;
                case (byte_cnt)
                    3'd0: byte_in.data = win_cmd;
                    3'd1: byte_in.data = win_lo[15:8];
                    3'd2: byte_in.data = win_lo[7:0];
                    3'd3: byte_in.data = win_hi[15:8];
                    default: byte_in.data = win_hi[7:0];
                endcase
            end
            ST_RAMWR: begin
                byte_push    = byte_space;
                byte_in.data = CMD_RAMWR;
                byte_in.last = 1'b0; // pixels follow in the same packet
            end
            ST_PIXELS: begin
                byte_push    = byte_space;
                byte_in.user = 1'b1;
                byte_in.last = byte_cnt == 3'd2 && pix_cnt == pixel_count - 16'd1;
                case (byte_cnt)
                    3'd0: byte_in.data = color[23:16];
                    3'd1: byte_in.data = color[15:8];
                    default: byte_in.data = color[7:0];
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state       <= ST_START;
            byte_cnt    <= '0;
            pix_cnt     <= '0;
            pause_cnt   <= '0;
            settle_cnt  <= 1'b0;
            seg_index   <= '0;
            digit_index <= '0;
        end else begin
            case (state)
                ST_START: state <= ST_SWRESET;
                ST_SWRESET: if (byte_push) state <= ST_PAUSE;
                ST_PAUSE: begin
                    if (byte_space) begin // counts from swreset acceptance
                        pause_cnt <= pause_cnt + 1'b1;
                        if (pause_cnt == PAUSE_W'(PAUSE_CYCLES - 1)) begin
                            state <= ST_SLPOUT;
                        end
                    end
                end
                ST_SLPOUT: if (byte_push) state <= ST_INVON;
                ST_INVON:  if (byte_push) state <= ST_DISPON;
                ST_DISPON: if (byte_push) state <= ST_CASET_FULL;
                ST_CASET_FULL, ST_RASET_FULL, ST_CASET, ST_RASET: begin
                    if (byte_push) begin
                        byte_cnt <= win_done ? 3'd0 : byte_cnt + 3'd1;
                    end
                    if (win_done) begin
                        case (state)
                            ST_CASET_FULL: state <= ST_RASET_FULL;
                            ST_RASET_FULL: state <= ST_IDLE;
                            ST_CASET:      state <= ST_RASET;
                            default:       state <= ST_RAMWR;
                        endcase
                    end
                end
                ST_IDLE: begin
                    pause_cnt <= '0;
                    if (time_valid) begin
                        state <= ST_SETTLE;
                    end
                end
                ST_SETTLE: begin
                    settle_cnt <= !settle_cnt;
                    if (settle_cnt) begin // rom and window stages refilled
                        state <= ST_CASET;
                    end
                end
                ST_RAMWR: if (byte_push) state <= ST_PIXELS;
                ST_PIXELS: begin
                    if (byte_push) begin
                        byte_cnt <= byte_cnt == 3'd2 ? 3'd0 : byte_cnt + 3'd1;
                        if (byte_cnt == 3'd2) begin
                            pix_cnt <= pix_done ? 16'd0 : pix_cnt + 16'd1;
                        end
                    end
                    if (pix_done) begin
                        if (frame_done) begin
                            seg_index   <= '0;
                            digit_index <= '0;
                            state       <= ST_IDLE;
                        end else if (seg_index == 3'(NUM_SEGMENTS - 1)) begin
                            seg_index   <= '0;
                            digit_index <= digit_index + 3'd1;
                            state       <= ST_SETTLE;
                        end else begin
                            seg_index <= seg_index + 3'd1;
                            state     <= ST_SETTLE;
                        end
                    end
                end
                default: state <= ST_START;
            endcase
        end
    end

    // digits held for the whole frame
    always_ff @(posedge CLK) begin
        if (state == ST_IDLE && time_valid) begin
            digits_q <= time_digits;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/time_display_top.sv ====
`default_nettype none

module time_display_top #(
    parameter int          SYMBOL_PITCH     = 30,
    parameter int          OFFSET_X         = 0,
    parameter int          OFFSET_Y         = 0,
    parameter int          PAUSE_CYCLES     = 500,
    parameter logic [23:0] FONT_COLOR       = 24'hFFFFFF,
    parameter logic [23:0] BACKGROUND_COLOR = 24'h000000
) (
    input  wire  logic                  CLK,
    input  wire  logic                  RESET,
    input  wire  lcd_pkg::time_digits_t time_digits,
    input  wire  logic                  time_valid,
    output logic [7:0]                  m_axis_tdata,
    output logic                        m_axis_tuser,
    output logic                        m_axis_tlast,
    output logic                        m_axis_tvalid,
    input  wire  logic                  m_axis_tready
);

    import lcd_pkg::*;

    lcd_byte_t   byte_in;
    logic        byte_push;
    logic        byte_space;
    logic [2:0]  seg_index;
    logic [2:0]  digit_index;
    seg_rect_t   seg_rect;
    lcd_window_t window;
    logic [15:0] pixel_count;

    lcd_ctrl #(
        .PAUSE_CYCLES     (PAUSE_CYCLES),
        .FONT_COLOR       (FONT_COLOR),
        .BACKGROUND_COLOR (BACKGROUND_COLOR)
    ) lcd_ctrl_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .time_digits (time_digits),
        .time_valid  (time_valid),
        .byte_space  (byte_space),
        .byte_in     (byte_in),
        .byte_push   (byte_push),
        .seg_index   (seg_index),
        .digit_index (digit_index),
        .window      (window),
        .pixel_count (pixel_count)
    );

    segment_rom segment_rom_i (
        .CLK       (CLK),
        .seg_index (seg_index),
        .seg_rect  (seg_rect)
    );

    window_calc #(
        .SYMBOL_PITCH (SYMBOL_PITCH),
        .OFFSET_X     (OFFSET_X),
        .OFFSET_Y     (OFFSET_Y)
    ) window_calc_i (
        .CLK         (CLK),
        .digit_index (digit_index),
        .seg_rect    (seg_rect),
        .window      (window),
        .pixel_count (pixel_count)
    );

    stream_out stream_out_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .byte_in       (byte_in),
        .byte_push     (byte_push),
        .byte_space    (byte_space),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic RESET
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    initial begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(negedge CLK);
        RESET = 1'b0; // released on a falling edge
    end

endmodule

`default_nettype wire

// ==== testbench/tb_time_display.sv ====
`default_nettype none

module tb_time_display;

    timeunit 1ns;
    timeprecision 100ps;

    import lcd_pkg::*;

    localparam int          PAUSE_CYCLES  = 20;
    localparam int          OFFSET_X      = 4;
    localparam int          OFFSET_Y      = 8;
    localparam int          PITCH         = 30;
    localparam logic [23:0] FONT_RGB      = 24'hFFFFFF;
    localparam logic [23:0] BACK_RGB      = 24'h000000;
    localparam int          MAX_LINES     = 32;
    localparam int          MID_STROBE_AT = 300; // bytes into a frame

    logic         CLK;
    logic         RESET;
    time_digits_t time_digits;
    logic         time_valid;
    logic [7:0]   m_axis_tdata;
    logic         m_axis_tuser;
    logic         m_axis_tlast;
    logic         m_axis_tvalid;
    logic         m_axis_tready;

    lcd_byte_t    exp_q[$];
    int           pix_pos_q[$]; // 0 = command or window byte, 1..3 = r g b
    lcd_byte_t    held_byte;
    logic         stalled;
    logic [31:0]  lcg_state;
    int           cycle_no;
    int           accepted;
    int           swreset_cycle;
    logic         gap_checked;
    logic [15:0]  font_bytes;
    int           n_lines;
    longint       budget;
    logic         budget_ready;
    time_digits_t line_digits[MAX_LINES];
    int           line_density[MAX_LINES];
    int           line_font[MAX_LINES];

    tb_clock clock_gen_i (
        .CLK   (CLK),
        .RESET (RESET)
    );

    time_display_top #(
        .SYMBOL_PITCH (PITCH),
        .OFFSET_X     (OFFSET_X),
        .OFFSET_Y     (OFFSET_Y),
        .PAUSE_CYCLES (PAUSE_CYCLES)
    ) time_display_top_i (
        .CLK           (CLK),
        .RESET         (RESET),
        .time_digits   (time_digits),
        .time_valid    (time_valid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input lcd_byte_t got, input lcd_byte_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf(
                "ERR %s got data %h user %h last %h expected data %h user %h last %h",
                name, got.data, got.user, got.last, exp.data, exp.user, exp.last));
        end
    endtask

    task automatic check_count(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // 20x40 cell, stroke 4
    function automatic seg_rect_t rect_of(input int s);
        case (s)
            0: return {8'd0, 8'd19, 8'd0, 8'd3};
            1: return {8'd16, 8'd19, 8'd0, 8'd19};
            2: return {8'd16, 8'd19, 8'd20, 8'd39};
            3: return {8'd0, 8'd19, 8'd36, 8'd39};
            4: return {8'd0, 8'd3, 8'd20, 8'd39};
            5: return {8'd0, 8'd3, 8'd0, 8'd19};
            default: return {8'd0, 8'd19, 8'd18, 8'd21};
        endcase
    endfunction

    function automatic digit_seg_t digit_bits(input time_digits_t t, input int d);
        case (d)
            0: return t.hour_h;
            1: return t.hour_l;
            2: return t.min_h;
            3: return t.min_l;
            4: return t.sec_h;
            default: return t.sec_l;
        endcase
    endfunction

    task automatic push_exp(input logic [7:0] data, input logic user, input logic last,
                            input int pos);
        exp_q.push_back({data, user, last});
        pix_pos_q.push_back(pos);
    endtask

    task automatic push_window(input logic [7:0] cmd, input logic [15:0] lo,
                               input logic [15:0] hi);
        push_exp(cmd, 1'b0, 1'b0, 0);
        push_exp(lo[15:8], 1'b1, 1'b0, 0);
        push_exp(lo[7:0], 1'b1, 1'b0, 0);
        push_exp(hi[15:8], 1'b1, 1'b0, 0);
        push_exp(hi[7:0], 1'b1, 1'b1, 0);
    endtask

    task automatic build_startup();
        push_exp(8'h01, 1'b0, 1'b1, 0);
        push_exp(8'h11, 1'b0, 1'b1, 0);
        push_exp(8'h21, 1'b0, 1'b1, 0);
        push_exp(8'h29, 1'b0, 1'b1, 0);
        push_window(8'h2A, 16'd0, 16'd239);
        push_window(8'h2B, 16'd0, 16'd239);
    endtask

    task automatic build_frame(input time_digits_t t);
        seg_rect_t   r;
        int          x0;
        int          n;
        logic [23:0] rgb;
        digit_seg_t  bits;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            bits = digit_bits(t, d);
            for (int s = 0; s < NUM_SEGMENTS; s++) begin
                r  = rect_of(s);
                x0 = OFFSET_X + d * PITCH;
                push_window(8'h2A, 16'(x0 + r.x_start), 16'(x0 + r.x_end));
                push_window(8'h2B, 16'(OFFSET_Y + r.y_start), 16'(OFFSET_Y + r.y_end));
                push_exp(8'h2C, 1'b0, 1'b0, 0);
                rgb = bits[s] ? FONT_RGB : BACK_RGB;
                n   = (r.x_end - r.x_start + 1) * (r.y_end - r.y_start + 1);
                for (int p = 0; p < n; p++) begin
                    for (int k = 0; k < 3; k++) begin
                        push_exp(8'(rgb >> (16 - 8 * k)), 1'b1, p == n - 1 && k == 2, k + 1);
                    end
                end
            end
        end
    endtask

    task automatic take_byte(input lcd_byte_t got);
        lcd_byte_t exp;
        int        pos;
        exp = exp_q.pop_front();
        pos = pix_pos_q.pop_front();
        check_byte("m_axis_byte", got, exp);
        if (accepted == 0) begin
            swreset_cycle = cycle_no;
        end
        if (pos != 0 && got.data == 8'(FONT_RGB >> (24 - 8 * pos))) begin
            font_bytes++;
        end
        accepted++;
    endtask

    // one falling edge: sample the stream, then drive the next inputs
    task automatic step(input int density, input logic strobe, input time_digits_t digits);
        lcd_byte_t got;
        logic      valid;
        @(negedge CLK);
        cycle_no++;
        got           = {m_axis_tdata, m_axis_tuser, m_axis_tlast};
        valid         = m_axis_tvalid;
        time_valid    = strobe;
        time_digits   = digits;
        lcg_state     = lcg_next(lcg_state);
        m_axis_tready = (int'(lcg_state[30:16]) % 100) < density;
        if (stalled) begin
            if (valid !== 1'b1) begin
                stop_on_error("tvalid dropped before its byte was accepted");
            end
            check_byte("m_axis_hold", got, held_byte);
        end
        if (valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_on_error("a byte appeared on the stream when none was expected");
            end
            if (accepted == 1 && !gap_checked) begin
                gap_checked = 1'b1;
                check_count("pause_gap", 16'(cycle_no - swreset_cycle), 16'(PAUSE_CYCLES + 1));
            end
            if (m_axis_tready) begin
                take_byte(got);
            end
        end else if (valid !== 1'b0) begin
            stop_on_error("tvalid is unknown");
        end
        stalled   = valid === 1'b1 && !m_axis_tready;
        held_byte = got;
    endtask

    task automatic read_trace();
        int         fd;
        int         got;
        string      line;
        int         dens;
        int         font;
        logic [7:0] hx[6];
        fd = $fopen("testbench/time_trace.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open testbench/time_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                got = $sscanf(line, "%h %h %h %h %h %h %d %d",
                              hx[0], hx[1], hx[2], hx[3], hx[4], hx[5], dens, font);
                if (got != 8) begin
                    stop_on_error({"malformed trace line: ", line});
                end
                if (n_lines == MAX_LINES) begin
                    stop_on_error("trace file has too many lines");
                end
                line_digits[n_lines]  = {hx[0][6:0], hx[1][6:0], hx[2][6:0],
                                         hx[3][6:0], hx[4][6:0], hx[5][6:0]};
                line_density[n_lines] = dens;
                line_font[n_lines]    = font;
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_frame(input int i);
        int           start;
        logic         mid_sent;
        time_digits_t decoy;
        decoy = ~line_digits[i];
        repeat (12) step(line_density[i], 1'b0, decoy); // idle, stream must stay quiet
        build_frame(line_digits[i]);
        font_bytes = '0;
        start      = accepted;
        mid_sent   = 1'b0;
        step(line_density[i], 1'b1, line_digits[i]);
        while (exp_q.size() > 0) begin
            if (!mid_sent && accepted - start >= MID_STROBE_AT) begin
                mid_sent = 1'b1;
                step(line_density[i], 1'b1, decoy); // strobe while drawing
            end else begin
                step(line_density[i], 1'b0, decoy);
            end
        end
        check_count("font_bytes", font_bytes, 16'(line_font[i]));
    endtask

    initial begin
        time_digits   = '0;
        time_valid    = 1'b0;
        m_axis_tready = 1'b0;
        stalled       = 1'b0;
        held_byte     = '0;
        lcg_state     = 32'h3902;
        cycle_no      = 0;
        accepted      = 0;
        swreset_cycle = 0;
        gap_checked   = 1'b0;
        font_bytes    = '0;
        n_lines       = 0;
        budget_ready  = 1'b0;
        read_trace();
        if (n_lines == 0) begin
            stop_on_error("trace file holds no test lines");
        end
        budget = 8 + PAUSE_CYCLES + 1000; // reset, pause and start-up bytes
        for (int i = 0; i < n_lines; i++) begin
            budget += 1200000 / (line_density[i] > 0 ? line_density[i] : 1);
        end
        budget_ready = 1'b1;
        build_startup();
        @(negedge RESET);
        if (m_axis_tvalid !== 1'b0) begin
            stop_on_error("tvalid is not low after reset");
        end
        while (exp_q.size() > 0) begin
            step(line_density[0], 1'b0, '0);
        end
        for (int i = 0; i < n_lines; i++) begin
            run_frame(i);
        end
        repeat (12) step(100, 1'b0, '0);
        $display("Simulation passed");
        $finish;
    end

    // 12000 cycles per frame at full ready, stretched by the density
    initial begin
        wait (budget_ready === 1'b1);
        repeat (budget) @(posedge CLK);
        stop_on_error("timeout, the expected byte stream did not finish in time");
    end

endmodule

`default_nettype wire

// ==== testbench/time_trace.txt ====
# hour_h hour_l min_h min_l sec_h sec_l: hex segment bits, a = bit 0 ... g = bit 6
# then ready density in percent and expected font-coloured pixel bytes in the frame
06 5B 4F 66 6D 7D 100 6480
3F 3F 3F 3F 3F 3F 73 8640
7F 7F 7F 7F 7F 7F 55 10080
00 00 00 00 00 00 90 0
5B 4F 6D 6F 3F 07 40 7200
06 6F 66 7F 5B 06 100 6240
01 02 04 08 10 20 65 1440
7F 00 7F 00 40 41 85 4080

// ==== sim.f ====
hdl/lcd_pkg.sv
hdl/segment_rom.sv
hdl/window_calc.sv
hdl/stream_out.sv
hdl/lcd_ctrl.sv
hdl/time_display_top.sv
testbench/tb_clock.sv
testbench/tb_time_display.sv
